// ==== design/mfp_timer_config.svh ====
`ifndef MFP_TIMER_CONFIG_SVH
`define MFP_TIMER_CONFIG_SVH

// timer channels in the subsystem, A and B
`define MFP_NUM_TIMERS 2

// cpu bus data width, also the width of each down counter
`define MFP_DATA_W 8

// register address width on the cpu bus
`define MFP_ADDR_W 3

`endif

// ==== design/mfp_timer_pkg.sv ====
`default_nettype none

`include "mfp_timer_config.svh"

package mfp_timer_pkg;

  // cpu visible register map
  typedef enum logic [`MFP_ADDR_W-1:0] {
    TACR = 3'd0,
    TBCR = 3'd1,
    TADR = 3'd2,
    TBDR = 3'd3,
    IPR  = 3'd4,
    IMR  = 3'd5
  } reg_addr_e;

  // stored mode field of a control register
  // 0 stop, 1..7 delay, 8 event, 9..15 pulse
  typedef logic [3:0] timer_mode_t;

  // control byte as seen on a write, out_rst is never stored
  typedef struct packed {
    logic        out_rst;
    timer_mode_t mode;
  } timer_ctrl_t;

  // prescaler code to tick period in CLK cycles
  function automatic logic [`MFP_DATA_W-1:0] prescale_len(input logic [2:0] code);
    case (code)
      3'd1:    prescale_len = 8'd4;
      3'd2:    prescale_len = 8'd10;
      3'd3:    prescale_len = 8'd16;
      3'd4:    prescale_len = 8'd50;
      3'd5:    prescale_len = 8'd64;
      3'd6:    prescale_len = 8'd100;
      3'd7:    prescale_len = 8'd200;
      // code 0 only shows up in stop and event mode where no prescaler runs
      default: prescale_len = 8'd1;
    endcase
  endfunction

endpackage

`default_nettype wire

// ==== design/timer_ctrl_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

interface timer_ctrl_if;

  // write strobes and shared write data from the decoder
  logic                   dat_we;
  logic                   ctrl_we;
  logic [`MFP_DATA_W-1:0] wdata;

  // channel status back towards the cpu
  logic [`MFP_DATA_W-1:0] count_val;
  logic [3:0]             control;

  // one cycle expiry strobe, picked up by the interrupt block at the top
  logic                   timeout;

  modport regs (output dat_we, ctrl_we, wdata, input count_val, control);

  modport timer (input dat_we, ctrl_we, wdata, output count_val, control, timeout);

endinterface

`default_nettype wire

// ==== design/mfp_timer_channel.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_timer_channel (
  input  wire         CLK,
  input  wire         rst_n,
  timer_ctrl_if.timer bus,
  input  wire         trig_in,
  output logic        t_out
);

  import mfp_timer_pkg::*;

  localparam int W = `MFP_DATA_W;

  timer_ctrl_t ctrl_wr;
  timer_mode_t mode_q;
  logic [W-1:0] reload_q;
  logic [W-1:0] count_q;
  logic [W-1:0] presc_cnt;
  logic [W-1:0] presc_len;
  logic         trig_s1;
  logic         trig_s2;
  logic         trig_s3;
  logic         timeout_q;
  logic         stopped;
  logic         event_mode;
  logic         delay_mode;
  logic         pulse_mode;
  logic         presc_tick;
  logic         trig_rise;
  logic         step;

  // bit 4 of the written byte resets the output and bits 3..0 hold the mode
  assign ctrl_wr = timer_ctrl_t'(bus.wdata[4:0]);

  // mode decode from the stored field
  assign stopped    = (mode_q == 4'd0);
  assign event_mode = (mode_q == 4'd8);
  assign delay_mode = !mode_q[3] && !stopped;
  assign pulse_mode = mode_q[3] && (mode_q[2:0] != 3'd0);

  assign presc_len = prescale_len(mode_q[2:0]);

  // >= keeps a prescaler change mid period from running the count past the end
  assign presc_tick = (delay_mode || pulse_mode) && (presc_cnt >= presc_len - 1'b1);

  assign trig_rise = trig_s2 && !trig_s3;

  // one counted step per tick with the synced trigger gating it in pulse mode
  always_comb begin
    step = 1'b0;
    if (delay_mode)
      step = presc_tick;
    else if (pulse_mode)
      step = presc_tick && trig_s2;
    else if (event_mode)
      step = trig_rise;
  end

  // prescaler stays at zero unless a prescaled mode is selected
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      presc_cnt <= '0;
    end else if (!(delay_mode || pulse_mode) || presc_tick) begin
      presc_cnt <= '0;
    end else begin
      presc_cnt <= presc_cnt + 1'b1;
    end
  end

  // two flop sync plus one more stage for the edge detect
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      trig_s1 <= 1'b0;
      trig_s2 <= 1'b0;
      trig_s3 <= 1'b0;
    end else begin
      trig_s1 <= trig_in;
      trig_s2 <= trig_s1;
      trig_s3 <= trig_s2;
    end
  end

  // reload value is written whatever the mode
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n)
      reload_q <= '0;
    else if (bus.dat_we)
      reload_q <= bus.wdata;
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mode_q    <= '0;
      count_q   <= '0;
      t_out     <= 1'b0;
      timeout_q <= 1'b0;
    end else begin
      timeout_q <= 1'b0;
      // a stopped channel takes the data write into the counter directly
      if (bus.dat_we && stopped) begin
        count_q <= bus.wdata;
      end else if (step) begin
        if (count_q == 1) begin
          // expiry reloads, toggles the pin and strobes the interrupt block
          count_q   <= reload_q;
          t_out     <= !t_out;
          timeout_q <= 1'b1;
        end else begin
          count_q <= count_q - 1'b1;
        end
      end
      // output reset comes last so it beats a toggle in the same cycle
      if (bus.ctrl_we) begin
        mode_q <= ctrl_wr.mode;
        if (ctrl_wr.out_rst)
          t_out <= 1'b0;
      end
    end
  end

  assign bus.count_val = count_q;
  assign bus.control   = mode_q;
  assign bus.timeout   = timeout_q;

endmodule

`default_nettype wire

// ==== design/mfp_bus_regs.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_bus_regs (
  input  wire                        cs,
  input  wire                        we,
  input  wire mfp_timer_pkg::reg_addr_e addr,
  input  wire [`MFP_DATA_W-1:0]      wdata,
  output logic [`MFP_DATA_W-1:0]     rdata,
  timer_ctrl_if.regs                 tmr_a,
  timer_ctrl_if.regs                 tmr_b,
  output logic                       ipr_we,
  output logic                       imr_we,
  input  wire [`MFP_NUM_TIMERS-1:0]  pending,
  input  wire [`MFP_NUM_TIMERS-1:0]  mask
);

  import mfp_timer_pkg::*;

  localparam int W = `MFP_DATA_W;

  logic wr;

  // a write is cs and we together, sampled by the target at the clock edge
  assign wr = cs && we;

  // per channel strobes, the channels see no address at all
  assign tmr_a.ctrl_we = wr && (addr == TACR);
  assign tmr_a.dat_we  = wr && (addr == TADR);
  assign tmr_b.ctrl_we = wr && (addr == TBCR);
  assign tmr_b.dat_we  = wr && (addr == TBDR);

  // both channels share the write data
  assign tmr_a.wdata = wdata;
  assign tmr_b.wdata = wdata;

  // interrupt block strobes
  assign ipr_we = wr && (addr == IPR);
  assign imr_we = wr && (addr == IMR);

  // read mux, zero when not selected
  always_comb begin
    rdata = '0;
    if (cs) begin
      case (addr)
        TACR:    rdata = W'(tmr_a.control);
        TBCR:    rdata = W'(tmr_b.control);
        // data addresses read the live counter, not the reload value
        TADR:    rdata = tmr_a.count_val;
        TBDR:    rdata = tmr_b.count_val;
        IPR:     rdata = W'(pending);
        IMR:     rdata = W'(mask);
        default: rdata = '0;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== design/mfp_irq_ctrl.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_irq_ctrl (
  input  wire                        CLK,
  input  wire                        rst_n,
  input  wire [`MFP_NUM_TIMERS-1:0]  timeout,
  input  wire                        ipr_we,
  input  wire                        imr_we,
  input  wire [`MFP_DATA_W-1:0]      wdata,
  output logic [`MFP_NUM_TIMERS-1:0] pending,
  output logic [`MFP_NUM_TIMERS-1:0] mask,
  output logic                       irq
);

  localparam int N = `MFP_NUM_TIMERS;

  logic [N-1:0] clr;

  // a 1 written to IPR clears that bit
  assign clr = ipr_we ? wdata[N-1:0] : '0;

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      pending <= '0;
      mask    <= '0;
      irq     <= 1'b0;
    end else begin
      // set after clear so a timeout in the same cycle is not lost
      pending <= (pending & ~clr) | timeout;
      if (imr_we)
        mask <= wdata[N-1:0];
      // level output, one cycle behind pending
      irq <= |(pending & mask);
    end
  end

endmodule

`default_nettype wire

// ==== design/mfp_timers_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_timers_top (
  input  wire                       CLK,
  input  wire                       rst_n,
  input  wire                       cs,
  input  wire                       we,
  input  wire [`MFP_ADDR_W-1:0]     addr,
  input  wire [`MFP_DATA_W-1:0]     wdata,
  output wire [`MFP_DATA_W-1:0]     rdata,
  input  wire [`MFP_NUM_TIMERS-1:0] trig_in,
  output wire [`MFP_NUM_TIMERS-1:0] t_out,
  output wire                       irq
);

  import mfp_timer_pkg::*;

  wire                       ipr_we;
  wire                       imr_we;
  wire [`MFP_NUM_TIMERS-1:0] pending;
  wire [`MFP_NUM_TIMERS-1:0] mask;

  // one register link per channel
  timer_ctrl_if tmr_a_if ();
  timer_ctrl_if tmr_b_if ();

  mfp_bus_regs u_bus_regs (
    .cs      (cs),
    .we      (we),
    .addr    (reg_addr_e'(addr)),
    .wdata   (wdata),
    .rdata   (rdata),
    .tmr_a   (tmr_a_if.regs),
    .tmr_b   (tmr_b_if.regs),
    .ipr_we  (ipr_we),
    .imr_we  (imr_we),
    .pending (pending),
    .mask    (mask)
  );

  // timer A is bit 0 everywhere
  mfp_timer_channel u_timer_a (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .bus     (tmr_a_if.timer),
    .trig_in (trig_in[0]),
    .t_out   (t_out[0])
  );

  mfp_timer_channel u_timer_b (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .bus     (tmr_b_if.timer),
    .trig_in (trig_in[1]),
    .t_out   (t_out[1])
  );

  // expiry strobes go straight from the channels to the pending bits
  mfp_irq_ctrl u_irq_ctrl (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .timeout ({tmr_b_if.timeout, tmr_a_if.timeout}),
    .ipr_we  (ipr_we),
    .imr_we  (imr_we),
    .wdata   (wdata),
    .pending (pending),
    .mask    (mask),
    .irq     (irq)
  );

endmodule

`default_nettype wire

// ==== verification/mfp_timers_sva.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_timers_sva (
  input wire                   CLK,
  input wire                   rst_n,
  input wire                   timeout,
  input wire                   t_out,
  input wire                   ctrl_we,
  input wire [3:0]             mode,
  input wire [`MFP_DATA_W-1:0] count_val
);

  // failed assertions so far for the testbench to poll
  int fail_cnt = 0;

  // expiry strobe never lasts longer than one cycle
  a_timeout_pulse: assert property (@(posedge CLK) disable iff (!rst_n)
    timeout |=> !timeout)
    else begin
      fail_cnt++;
      $error("timeout stayed high for more than one cycle");
    end

  // the pin moves only on an expiry or right after a control write
  a_tout_cause: assert property (@(posedge CLK) disable iff (!rst_n)
    !$stable(t_out) |-> timeout || $past(ctrl_we))
    else begin
      fail_cnt++;
      $error("t_out changed without a timeout or a control write");
    end

  // a running counter with a nonzero value never reaches zero
  a_count_nonzero: assert property (@(posedge CLK) disable iff (!rst_n)
    (mode != 4'd0 && count_val != '0) |=> count_val != '0)
    else begin
      fail_cnt++;
      $error("counter reached zero while running");
    end

endmodule

bind mfp_timer_channel mfp_timers_sva sva_inst (
  .CLK       (CLK),
  .rst_n     (rst_n),
  .timeout   (timeout_q),
  .t_out     (t_out),
  .ctrl_we   (bus.ctrl_we),
  .mode      (mode_q),
  .count_val (count_q)
);

`default_nettype wire

// ==== verification/mfp_timers_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "mfp_timer_config.svh"

module mfp_timers_tb;

  typedef logic [8*24-1:0] text_t;

  logic                       CLK = 1'b0;
  logic                       rst_n;
  logic                       cs;
  logic                       we;
  logic [`MFP_ADDR_W-1:0]     addr;
  logic [`MFP_DATA_W-1:0]     wdata;
  wire  [`MFP_DATA_W-1:0]     rdata;
  logic [`MFP_NUM_TIMERS-1:0] trig_in;
  wire  [`MFP_NUM_TIMERS-1:0] t_out;
  wire                        irq;

  // commands loaded from the data file
  text_t cmd_op [$];
  text_t cmd_name [$];
  int    cmd_a [$];
  int    cmd_b [$];
  int    cmd_lim [$];

  int          limit_sum = 0;
  int          cycle_limit = 0;
  int          cycle_count = 0;
  logic [31:0] rand_state = 32'h4443_8a2b;

  // last reload and mode written per channel give the expected expiry time
  logic [`MFP_DATA_W-1:0] reload_seen [`MFP_NUM_TIMERS];
  logic [3:0]             mode_seen [`MFP_NUM_TIMERS];

  mfp_timers_top mfp_timers_top_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .cs      (cs),
    .we      (we),
    .addr    (addr),
    .wdata   (wdata),
    .rdata   (rdata),
    .trig_in (trig_in),
    .t_out   (t_out),
    .irq     (irq)
  );

  // 8 ns period
  always #4 CLK = ~CLK;

  // whole run budget is set once the data file is loaded
  always @(posedge CLK) begin
    cycle_count <= cycle_count + 1;
    if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
      $display("timeout: the run went past %0d cycles", cycle_limit);
      fail_run();
    end
  end

  // an assertion failure in either channel ends the run at once
  always @(negedge CLK) begin
    if (assert_failures() != 0) begin
      $display("an assertion in a timer channel failed");
      fail_run();
    end
  end

  task automatic fail_run();
    $display("Test failures found");
    $fatal(1);
  endtask

  // failed assertions counted inside both bound checkers
  function automatic int assert_failures();
    return mfp_timers_top_inst.u_timer_a.sva_inst.fail_cnt +
           mfp_timers_top_inst.u_timer_b.sva_inst.fail_cnt;
  endfunction

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // tick period of each prescaler code in CLK cycles
  function automatic int tick_period(input logic [2:0] code);
    case (code)
      3'd1:    return 4;
      3'd2:    return 10;
      3'd3:    return 16;
      3'd4:    return 50;
      3'd5:    return 64;
      3'd6:    return 100;
      3'd7:    return 200;
      default: return 0;
    endcase
  endfunction

  task automatic check_byte(input text_t name, input logic [`MFP_DATA_W-1:0] expected,
                            input logic [`MFP_DATA_W-1:0] actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s expected %02h actual %02h", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_bit(input text_t name, input logic expected, input logic actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s expected %b actual %b", name, expected, actual);
      fail_run();
    end
  endtask

  task automatic check_count(input text_t name, input int expected, input int actual);
    if (actual !== expected) begin
      $display("CHECK FAILED %0s expected %0d cycles actual %0d cycles", name, expected, actual);
      fail_run();
    end
  endtask

  // the write is sampled on the second rising edge where the task returns
  task automatic bus_write(input logic [`MFP_ADDR_W-1:0] a, input logic [`MFP_DATA_W-1:0] d);
    @(posedge CLK);
    cs    <= 1'b1;
    we    <= 1'b1;
    addr  <= a;
    wdata <= d;
    @(posedge CLK);
    cs <= 1'b0;
    we <= 1'b0;
    if (a == 3'd2 || a == 3'd3)
      reload_seen[a - 3'd2] = d;
    else if (a <= 3'd1)
      mode_seen[a] = d[3:0];
  endtask

  // rdata is combinational and taken mid cycle
  task automatic bus_read(input logic [`MFP_ADDR_W-1:0] a, output logic [`MFP_DATA_W-1:0] d);
    @(posedge CLK);
    cs   <= 1'b1;
    we   <= 1'b0;
    addr <= a;
    @(negedge CLK);
    d = rdata;
    @(posedge CLK);
    cs <= 1'b0;
  endtask

  // pulses are two cycles high and two low with room for the synchronizer after
  task automatic pulse_trigger(input int ch, input int pulses);
    repeat (pulses) begin
      @(posedge CLK);
      trig_in[ch] <= 1'b1;
      repeat (2) @(posedge CLK);
      trig_in[ch] <= 1'b0;
      @(posedge CLK);
    end
    repeat (4) @(posedge CLK);
  endtask

  task automatic wait_irq(input text_t name, input int ch, input int limit);
    int cycles;
    int expected;
    cycles = 0;
    while (irq !== 1'b1 && cycles < limit) begin
      @(negedge CLK);
      cycles++;
    end
    if (irq !== 1'b1) begin
      $display("%0s: irq did not rise within %0d cycles", name, limit);
      fail_run();
    end
    // expiry lands N*P edges after the control write
    // pending and irq add one edge each and show on the falling edge after
    expected = reload_seen[ch] * tick_period(mode_seen[ch][2:0]) + 3;
    check_count(name, expected, cycles);
  endtask

  // random reload N and k pulses before the N-k pulses that reach expiry
  task automatic event_count(input text_t name, input int ch, input int k);
    logic [`MFP_DATA_W-1:0] n;
    logic [`MFP_DATA_W-1:0] got;
    logic [`MFP_ADDR_W-1:0] data_addr;
    logic [`MFP_ADDR_W-1:0] ctrl_addr;
    rand_state = lcg_next(rand_state);
    n = k + 1 + (rand_state[23:8] % (255 - k));
    data_addr = 2 + ch;
    ctrl_addr = ch;
    bus_write(data_addr, n);
    // event mode together with the output reset so the pin starts low
    bus_write(ctrl_addr, 8'h18);
    pulse_trigger(ch, k);
    bus_read(data_addr, got);
    check_byte(name, n - k, got);
    @(negedge CLK);
    check_bit(name, 1'b0, t_out[ch]);
    pulse_trigger(ch, n - k);
    bus_read(data_addr, got);
    check_byte(name, n, got);
    @(negedge CLK);
    check_bit(name, 1'b1, t_out[ch]);
    bus_read(3'd4, got);
    check_bit(name, 1'b1, got[ch]);
  endtask

  task automatic load_commands();
    int                 fd;
    int                 n;
    int                 a;
    int                 b;
    int                 lim;
    text_t              tok;
    text_t              nm;
    logic [8*160-1:0]   rest;
    bit                 done;
    fd = $fopen("verification/mfp_timers_testdata.txt", "r");
    if (fd == 0) begin
      $display("could not open the test data file");
      fail_run();
    end
    done = 1'b0;
    while (!done) begin
      n = $fscanf(fd, "%s", tok);
      if (n != 1) begin
        done = 1'b1;
      end else if (tok == "#") begin
        // skip the rest of a column note line
        n = $fgets(rest, fd);
      end else begin
        n = $fscanf(fd, "%s %h %h %d", nm, a, b, lim);
        if (n != 4) begin
          $display("malformed command %0s in the test data file", tok);
          fail_run();
        end
        cmd_op.push_back(tok);
        cmd_name.push_back(nm);
        cmd_a.push_back(a);
        cmd_b.push_back(b);
        cmd_lim.push_back(lim);
        limit_sum += lim;
      end
    end
    $fclose(fd);
  endtask

  task automatic run_command(input int i);
    logic [`MFP_DATA_W-1:0] got;
    int                     a;
    int                     b;
    a = cmd_a[i];
    b = cmd_b[i];
    case (cmd_op[i])
      "WR":   bus_write(a[2:0], b[7:0]);
      "RD": begin
        bus_read(a[2:0], got);
        check_byte(cmd_name[i], b[7:0], got);
      end
      "TRIG":    pulse_trigger(a, b);
      "WAITIRQ": wait_irq(cmd_name[i], a, cmd_lim[i]);
      "TOUT": begin
        @(negedge CLK);
        check_bit(cmd_name[i], b[0], t_out[a]);
      end
      "IRQ": begin
        @(negedge CLK);
        check_bit(cmd_name[i], b[0], irq);
      end
      "IDLE": repeat (a) @(posedge CLK);
      "EVT":  event_count(cmd_name[i], a, b);
      default: begin
        $display("unknown command %0s in the test data file", cmd_op[i]);
        fail_run();
      end
    endcase
  endtask

  initial begin
    rst_n   = 1'b0;
    cs      = 1'b0;
    we      = 1'b0;
    addr    = '0;
    wdata   = '0;
    trig_in = '0;
    load_commands();
    cycle_limit = limit_sum + 1000;
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;
    @(posedge CLK);
    for (int i = 0; i < cmd_op.size(); i++)
      run_command(i);
    @(negedge CLK);
    if (assert_failures() != 0) begin
      $display("an assertion in a timer channel failed during the run");
      fail_run();
    end else begin
      $display("All tests passed!");
      $finish;
    end
  end

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+design
design/mfp_timer_pkg.sv
design/timer_ctrl_if.sv
design/mfp_timer_channel.sv
design/mfp_bus_regs.sv
design/mfp_irq_ctrl.sv
design/mfp_timers_top.sv
verification/mfp_timers_sva.sv
verification/mfp_timers_tb.sv

// ==== verification/mfp_timers_testdata.txt ====
# op name a b limit : a and b are hex, limit is the line's cycle budget in decimal
# WR addr data | RD addr expected | TRIG ch pulses | WAITIRQ ch 0 | TOUT ch expected | IRQ 0 expected | IDLE cycles 0 | EVT ch pulses
RD rst_tacr 0 00 4
RD rst_tbcr 1 00 4
RD rst_tadr 2 00 4
RD rst_tbdr 3 00 4
RD rst_ipr 4 00 4
RD rst_imr 5 00 4
RD rst_unused 6 00 4
TOUT rst_tout_a 0 0 2
TOUT rst_tout_b 1 0 2
IRQ rst_irq 0 0 2
WR load_tadr 2 5a 4
RD stopped_tadr 2 5a 4
TRIG stopped_trig_b 1 3 30
RD stopped_tbdr 3 00 4
EVT event_a 0 0c 1200
WR stop_a 0 00 4
WR clear_ipr_a 4 01 4
RD cleared_ipr_a 4 00 4
WR load_tbdr 3 05 4
WR unmask_b 5 02 4
WR start_b 1 01 4
WAITIRQ delay_irq_b 1 0 30
TOUT delay_tout_b 1 1 2
WR stop_b 1 00 4
WR clear_ipr_b 4 02 4
RD cleared_ipr_b 4 00 4
IRQ cleared_irq 0 0 2
WR mask_b 5 00 4
WR reload_b 3 03 4
WR restart_b 1 01 4
IDLE masked_run 14 0 24
RD masked_ipr 4 02 4
IRQ masked_irq 0 0 2
WR stop_b_again 1 00 4
WR clear_ipr_b2 4 02 4
RD cleared_ipr_b2 4 00 4
WR load_tadr_run 2 80 4
WR start_a 0 01 4
IDLE run_a 14 0 24
WR freeze_a 0 00 4
RD frozen_tadr 2 7b 4
IDLE hold_a 32 0 54
RD still_tadr 2 7b 4
TOUT tout_a_set 0 1 2
WR out_rst_a 0 10 4
TOUT tout_a_clr 0 0 2
RD ctrl_after_rst 0 00 4
